// ==== Bender.yml ====
package:
  name: mini_core

sources:
  - files:
      - design/corePkg.sv
      - design/instrDecoder.sv
      - design/registerFile.sv
      - design/executeStage.sv
      - design/miniCore.sv
  - target: simulation
    files:
      - verification/miniCore_checker.sv
      - verification/miniCoreTb.sv

// ==== design/corePkg.sv ====
package corePkg;

    localparam int dataWidth = 32;

    typedef logic [4:0] regAddr_t;

    // R-format view
    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields_t;

    // I-format view
    typedef struct packed {
        logic [5:0]  opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm;
    } iFields_t;

    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instrWord_t;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddi    = 6'h08;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;

    // Funct field under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        immNone,
        immSignExt,
        immZeroExt
    } immKind_t;

    typedef enum logic [4:0] {
        causeRI = 5'd10,
        causeOv = 5'd12
    } excCause_t;

    typedef struct packed {
        aluOp_t     aluOp;
        immKind_t   immKind;
        regAddr_t   srcA;
        regAddr_t   srcB;
        regAddr_t   dest;
        logic [4:0] shamt;
        logic       checkOverflow;
        logic       unknown;
    } ctrl_t;

    typedef struct packed {
        logic                 valid;
        regAddr_t             dest;
        logic [dataWidth-1:0] data;
        logic [31:0]          pc;
    } wbBundle_t;

endpackage

// ==== design/executeStage.sv ====
module executeStage (
    input  bit                             clk,
    input  bit                             reset,
    input  bit                             inValid,
    input  logic [31:0]                    inPc,
    input  corePkg::ctrl_t                 ctrl,
    input  logic [15:0]                    imm,
    input  logic [corePkg::dataWidth-1:0]  regA,
    input  logic [corePkg::dataWidth-1:0]  regB,
    output corePkg::wbBundle_t             wb,
    output bit                             excStrobe,
    output corePkg::excCause_t             excCause,
    output logic [31:0]                    excPc
);
    import corePkg::*;

    localparam int msb = dataWidth - 1;

    logic                 eValid;
    logic [31:0]          ePc;
    ctrl_t                eCtrl;
    logic [15:0]          eImm;
    logic [dataWidth-1:0] eRegA;
    logic [dataWidth-1:0] eRegB;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] fwdB;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic [dataWidth-1:0] result;
    logic                 overflow;
    logic                 raiseExc;

    // Stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            eValid <= 1'b0;
        end else begin
            eValid <= inValid;
        end
        ePc <= inPc;
        eCtrl <= ctrl;
        eImm <= imm;
        eRegA <= regA;
        eRegB <= regB;
    end

    // Result of the previous instruction overrides the captured value
    assign opA = (wb.valid && wb.dest == eCtrl.srcA) ? wb.data : eRegA;
    assign fwdB = (wb.valid && wb.dest == eCtrl.srcB) ? wb.data : eRegB;

    always_comb begin
        case (eCtrl.immKind)
            immSignExt: immExt = {{(dataWidth - 16){eImm[15]}}, eImm};
            immZeroExt: immExt = {{(dataWidth - 16){1'b0}}, eImm};
            default:    immExt = '0;
        endcase
    end

    assign opB = (eCtrl.immKind == immNone) ? fwdB : immExt;

    assign sum = opA + opB;
    assign diff = opA - opB;

    always_comb begin
        overflow = 1'b0;
        result = sum;
        case (eCtrl.aluOp)
            aluAdd: begin
                result = sum;
                overflow = (opA[msb] == opB[msb]) && (sum[msb] != opA[msb]);
            end
            aluSub: begin
                result = diff;
                overflow = (opA[msb] != opB[msb]) && (diff[msb] != opA[msb]);
            end
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluXor:  result = opA ^ opB;
            aluNor:  result = ~(opA | opB);
            aluSlt:  result = {{msb{1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu: result = {{msb{1'b0}}, opA < opB};
            aluSll:  result = opB << eCtrl.shamt;
            // Immediate lands in the upper half
            aluLui:  result = opB << 16;
            default: result = sum;
        endcase
    end

    assign raiseExc = eCtrl.unknown || (eCtrl.checkOverflow && overflow);

    // Writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
            excStrobe <= 1'b0;
        end else begin
            wb.valid <= eValid && !raiseExc && eCtrl.dest != '0;
            excStrobe <= eValid && raiseExc;
        end
        wb.dest <= eCtrl.dest;
        wb.data <= result;
        wb.pc <= ePc;
        excCause <= eCtrl.unknown ? causeRI : causeOv;
        excPc <= ePc;
    end

endmodule

// ==== design/instrDecoder.sv ====
module instrDecoder (
    input  corePkg::instrWord_t instr,
    output corePkg::ctrl_t      ctrl
);
    import corePkg::*;

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        ctrl.immKind = immNone;
        if (instr.r.opcode == opSpecial) begin
            // Register-register forms
            ctrl.srcA = instr.r.rs;
            ctrl.srcB = instr.r.rt;
            ctrl.dest = instr.r.rd;
            ctrl.shamt = instr.r.shamt;
            case (instr.r.funct)
                fnAdd: begin
                    ctrl.aluOp = aluAdd;
                    ctrl.checkOverflow = 1'b1;
                end
                fnAddu: ctrl.aluOp = aluAdd;
                fnSub: begin
                    ctrl.aluOp = aluSub;
                    ctrl.checkOverflow = 1'b1;
                end
                fnSubu: ctrl.aluOp = aluSub;
                fnAnd:  ctrl.aluOp = aluAnd;
                fnOr:   ctrl.aluOp = aluOr;
                fnXor:  ctrl.aluOp = aluXor;
                fnNor:  ctrl.aluOp = aluNor;
                fnSlt:  ctrl.aluOp = aluSlt;
                fnSltu: ctrl.aluOp = aluSltu;
                fnSll:  ctrl.aluOp = aluSll;
                default: ctrl.unknown = 1'b1;
            endcase
        end else begin
            // Immediate forms write rt
            ctrl.srcA = instr.i.rs;
            ctrl.dest = instr.i.rt;
            case (instr.i.opcode)
                opAddi: begin
                    ctrl.aluOp = aluAdd;
                    ctrl.immKind = immSignExt;
                    ctrl.checkOverflow = 1'b1;
                end
                opAddiu: begin
                    ctrl.aluOp = aluAdd;
                    ctrl.immKind = immSignExt;
                end
                opSlti: begin
                    ctrl.aluOp = aluSlt;
                    ctrl.immKind = immSignExt;
                end
                opAndi: begin
                    ctrl.aluOp = aluAnd;
                    ctrl.immKind = immZeroExt;
                end
                opOri: begin
                    ctrl.aluOp = aluOr;
                    ctrl.immKind = immZeroExt;
                end
                opXori: begin
                    ctrl.aluOp = aluXor;
                    ctrl.immKind = immZeroExt;
                end
                opLui: begin
                    ctrl.aluOp = aluLui;
                    ctrl.immKind = immZeroExt;
                end
                default: ctrl.unknown = 1'b1;
            endcase
        end
    end

endmodule

// ==== design/miniCore.sv ====
module miniCore #(
    parameter logic [31:0] resetPc = 32'hbfc00000
) (
    input  bit                  clk,
    input  bit                  reset,
    input  bit                  instrStrobe,
    input  corePkg::instrWord_t instr,
    output corePkg::wbBundle_t  wb,
    output bit                  excStrobe,
    output corePkg::excCause_t  excCause,
    output logic [31:0]         excPc
);
    import corePkg::*;

    logic                 dValid;
    instrWord_t           dInstr;
    logic [31:0]          dPc;
    logic [31:0]          pc;
    ctrl_t                dCtrl;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;

    // Every strobe is taken and tagged with the running pc
    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
            pc <= resetPc;
        end else begin
            dValid <= instrStrobe;
            if (instrStrobe) begin
                pc <= pc + 32'd4;
            end
        end
        if (instrStrobe) begin
            dInstr <= instr;
            dPc <= pc;
        end
    end

    // Decode and register read run side by side
    instrDecoder decoder (
        .instr (dInstr),
        .ctrl  (dCtrl)
    );

    registerFile regFile (
        .clk       (clk),
        .reset     (reset),
        .readAddrA (dCtrl.srcA),
        .readAddrB (dCtrl.srcB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .wb        (wb)
    );

    executeStage execute (
        .clk       (clk),
        .reset     (reset),
        .inValid   (dValid),
        .inPc      (dPc),
        .ctrl      (dCtrl),
        .imm       (dInstr.i.imm),
        .regA      (readDataA),
        .regB      (readDataB),
        .wb        (wb),
        .excStrobe (excStrobe),
        .excCause  (excCause),
        .excPc     (excPc)
    );

endmodule

// ==== design/registerFile.sv ====
module registerFile (
    input  bit                             clk,
    input  bit                             reset,
    input  corePkg::regAddr_t              readAddrA,
    input  corePkg::regAddr_t              readAddrB,
    output logic [corePkg::dataWidth-1:0]  readDataA,
    output logic [corePkg::dataWidth-1:0]  readDataB,
    input  corePkg::wbBundle_t             wb
);
    import corePkg::*;

    logic [dataWidth-1:0] regs [32];

    // Register 0 reads zero and a same-cycle write passes straight through
    function automatic logic [dataWidth-1:0] readPort(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.valid && wb.dest == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

// ==== filelist.f ====
design/corePkg.sv
design/instrDecoder.sv
design/registerFile.sv
design/executeStage.sv
design/miniCore.sv
verification/miniCore_checker.sv
verification/miniCoreTb.sv

// ==== verification/miniCoreTb.sv ====
module miniCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    import corePkg::*;

    localparam logic [31:0] resetPc = 32'hbfc00000;
    localparam int numCycles = 3000;
    localparam realtime clkPeriod = 100ns;

    typedef struct packed {
        logic        isExc;
        excCause_t   cause;
        regAddr_t    dest;
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] cycle;
    } retire_t;

    bit          clk;
    bit          reset;
    bit          instrStrobe;
    instrWord_t  instr;
    wbBundle_t   wb;
    bit          excStrobe;
    excCause_t   excCause;
    logic [31:0] excPc;

    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    retire_t     expectQ [$];
    int unsigned edgeCount;
    int unsigned acceptedCount;
    int unsigned retiredCount;
    int unsigned mismatchCount;
    int unsigned otherErrorCount;
    int unsigned checkerErrorCount;

    miniCore #(.resetPc(resetPc)) i_dut (
        .clk         (clk),
        .reset       (reset),
        .instrStrobe (instrStrobe),
        .instr       (instr),
        .wb          (wb),
        .excStrobe   (excStrobe),
        .excCause    (excCause),
        .excPc       (excPc)
    );

    bind miniCore miniCore_checker outputChecker (
        .clk       (clk),
        .reset     (reset),
        .wb        (wb),
        .excStrobe (excStrobe)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Edge stamp for latency checks
    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    function automatic bit isLegal(instrWord_t w);
        if (w.r.opcode == opSpecial) begin
            case (w.r.funct)
                fnSll, fnAdd, fnAddu, fnSub, fnSubu, fnAnd,
                fnOr, fnXor, fnNor, fnSlt, fnSltu: return 1'b1;
                default: return 1'b0;
            endcase
        end
        case (w.i.opcode)
            opAddi, opAddiu, opSlti, opAndi, opOri, opXori, opLui: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [5:0] pickCode(int unsigned kind);
        case (kind)
            0: return fnAdd;
            1: return fnAddu;
            2: return fnSub;
            3: return fnSubu;
            4: return fnAnd;
            5: return fnOr;
            6: return fnXor;
            7: return fnNor;
            8: return fnSlt;
            9: return fnSltu;
            10: return fnSll;
            11: return opAddi;
            12: return opAddiu;
            13: return opSlti;
            14: return opAndi;
            15: return opOri;
            16: return opXori;
            default: return opLui;
        endcase
    endfunction

    // Small register range keeps dependencies close together
    function automatic instrWord_t randomInstr();
        instrWord_t  w;
        int unsigned kind;
        w = '0;
        if ($urandom_range(0, 99) < 5) begin
            w = $urandom;
            while (isLegal(w)) begin
                w = $urandom;
            end
            return w;
        end
        kind = $urandom_range(0, 17);
        if (kind < 11) begin
            w.r.opcode = opSpecial;
            w.r.rs = $urandom_range(0, 7);
            w.r.rt = $urandom_range(0, 7);
            w.r.rd = $urandom_range(0, 7);
            w.r.funct = pickCode(kind);
            if (w.r.funct == fnSll) begin
                w.r.rs = '0;
                w.r.shamt = $urandom_range(0, 31);
            end
        end else begin
            w.i.opcode = pickCode(kind);
            w.i.rs = $urandom_range(0, 7);
            w.i.rt = $urandom_range(0, 7);
            w.i.imm = $urandom;
        end
        return w;
    endfunction

    // Architectural model stepping one instruction at a time
    task automatic modelStep(instrWord_t w, logic [31:0] stamp);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immS;
        logic [31:0] immZ;
        logic [31:0] res;
        logic [32:0] wide;
        logic        ov;
        regAddr_t    dest;
        retire_t     ent;
        a = modelRegs[w.r.rs];
        b = modelRegs[w.r.rt];
        immS = {{16{w.i.imm[15]}}, w.i.imm};
        immZ = {16'h0000, w.i.imm};
        res = '0;
        ov = 1'b0;
        if (w.r.opcode == opSpecial) begin
            dest = w.r.rd;
            case (w.r.funct)
                fnAdd, fnAddu: begin
                    wide = {a[31], a} + {b[31], b};
                    res = wide[31:0];
                    ov = (w.r.funct == fnAdd) && (wide[32] != wide[31]);
                end
                fnSub, fnSubu: begin
                    wide = {a[31], a} - {b[31], b};
                    res = wide[31:0];
                    ov = (w.r.funct == fnSub) && (wide[32] != wide[31]);
                end
                fnAnd:  res = a & b;
                fnOr:   res = a | b;
                fnXor:  res = a ^ b;
                fnNor:  res = ~(a | b);
                fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fnSltu: res = (a < b) ? 32'd1 : 32'd0;
                fnSll:  res = b << w.r.shamt;
                default: res = '0;
            endcase
        end else begin
            dest = w.i.rt;
            case (w.i.opcode)
                opAddi, opAddiu: begin
                    wide = {a[31], a} + {immS[31], immS};
                    res = wide[31:0];
                    ov = (w.i.opcode == opAddi) && (wide[32] != wide[31]);
                end
                opSlti: res = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
                opAndi: res = a & immZ;
                opOri:  res = a | immZ;
                opXori: res = a ^ immZ;
                opLui:  res = {w.i.imm, 16'h0000};
                default: res = '0;
            endcase
        end
        ent = '0;
        ent.dest = dest;
        ent.data = res;
        ent.pc = modelPc;
        ent.cycle = stamp;
        modelPc += 32'd4;
        acceptedCount++;
        if (!isLegal(w)) begin
            ent.isExc = 1'b1;
            ent.cause = causeRI;
            expectQ.push_back(ent);
        end else if (ov) begin
            ent.isExc = 1'b1;
            ent.cause = causeOv;
            expectQ.push_back(ent);
        end else if (dest != '0) begin
            modelRegs[dest] = res;
            expectQ.push_back(ent);
        end
    endtask

    task automatic compareValue(string name, logic [31:0] got, logic [31:0] want);
        assert (got === want) else begin
            mismatchCount++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic checkRetirement(bit isExc);
        retire_t want;
        assert (expectQ.size() != 0) else begin
            otherErrorCount++;
            $display("unexpected %s strobe at %0t with no instruction pending",
                     isExc ? "exception" : "writeback", $time);
        end
        if (expectQ.size() != 0) begin
            want = expectQ.pop_front();
            retiredCount++;
            compareValue("excStrobe", isExc, want.isExc);
            compareValue("retire edge", edgeCount, want.cycle);
            if (isExc && want.isExc) begin
                compareValue("excCause", excCause, want.cause);
                compareValue("excPc", excPc, want.pc);
            end else if (!isExc && !want.isExc) begin
                compareValue("wb.dest", wb.dest, want.dest);
                compareValue("wb.data", wb.data, want.data);
                compareValue("wb.pc", wb.pc, want.pc);
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (wb.valid === 1'b1) begin
                checkRetirement(1'b0);
            end
            if (excStrobe) begin
                checkRetirement(1'b1);
            end
        end
    end

    initial begin
        instrWord_t w;
        void'($urandom(32'h18d0));
        reset = 1'b1;
        instrStrobe = 1'b0;
        instr = '0;
        modelPc = resetPc;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int c = 0; c < numCycles; c++) begin
            @(posedge clk);
            #1;
            if ($urandom_range(0, 3) != 0) begin
                w = randomInstr();
                instrStrobe = 1'b1;
                instr = w;
                // Sampled at the next edge and retired two edges later
                modelStep(w, edgeCount + 3);
            end else begin
                instrStrobe = 1'b0;
                instr = $urandom;
            end
        end
        @(posedge clk);
        #1;
        instrStrobe = 1'b0;
        repeat (6) @(negedge clk);
        assert (expectQ.size() == 0) else begin
            otherErrorCount++;
            $display("%0d expected retirements never appeared", expectQ.size());
        end
        checkerErrorCount = i_dut.outputChecker.failCount;
        $display("accepted %0d, retired %0d, mismatches %0d, other errors %0d, checker %0d",
                 acceptedCount, retiredCount, mismatchCount, otherErrorCount,
                 checkerErrorCount);
        if (mismatchCount == 0 && otherErrorCount == 0 && checkerErrorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #((numCycles + 20) * clkPeriod);
        $display("timeout: the run did not finish in its time budget");
        $display("test failed");
        $finish;
    end

endmodule

// ==== verification/miniCore_checker.sv ====
module miniCore_checker (
    input bit                 clk,
    input bit                 reset,
    input corePkg::wbBundle_t wb,
    input bit                 excStrobe
);
    timeunit 1ns;
    timeprecision 100ps;

    // Assertion failures seen so far
    int unsigned failCount;

    // A retiring instruction either writes or traps
    noDoubleRetire: assert property (@(posedge clk) disable iff (reset)
        !(wb.valid && excStrobe))
    else begin
        failCount++;
        $error("writeback and exception strobes are high in the same cycle");
    end

    noZeroDest: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> wb.dest != '0)
    else begin
        failCount++;
        $error("writeback strobe targets register 0");
    end

    // Quiet through reset and one cycle beyond
    quietAfterReset: assert property (@(posedge clk)
        reset |=> (!wb.valid && !excStrobe) ##1 (!wb.valid && !excStrobe))
    else begin
        failCount++;
        $error("strobe seen during reset or in the cycle after it");
    end

endmodule
